// File: plic_tests.dat
# kind (0 idle, 1 enable write, 2 claim read, 3 complete write, 4 other read) sources(hex)
# irq_enable wdata(hex, address for kind 4) expected_rdata(hex) expected_pulses
2 0 1 00000000 00000000 0
1 0 1 0000000a 00000000 0
0 a 1 00000000 00000000 0
2 a 1 00000000 00000000 0
0 0 1 00000000 00000000 0
1 0 1 0000001e 00000000 0
0 7 1 00000000 00000000 1
0 0 1 00000000 00000000 0
0 8 1 00000000 00000000 0
0 0 1 00000000 00000000 0
2 0 1 00000000 00000001 0
2 0 1 00000000 00000002 0
3 0 1 00000000 00000000 1
2 0 1 00000000 00000003 0
2 0 1 00000000 00000004 0
2 0 1 00000000 00000000 0
3 0 1 00000000 00000000 0
0 5 0 00000000 00000000 0
2 5 0 00000000 00000000 0
0 5 1 00000000 00000000 1
0 0 1 00000000 00000000 0
2 0 1 00000000 00000001 0
2 0 1 00000000 00000003 0
3 0 1 00000000 00000000 0
4 0 1 00123456 00000000 0
4 0 1 00200000 00000000 0
0 0 1 00000000 00000000 0

// File: sim.f
plic_pkg.sv
plic_gateway.sv
plic_core.sv
plic_bus_port.sv
plic_notify.sv
plic_top.sv
plic_checker.sv
plic_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module plic_tb -o plic_sim

output=$(./obj_dir/plic_sim)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
	exit 0
else
	exit 1
fi

// File: plic_tb.sv
`timescale 1ns/1ps

module plic_tb;

	localparam int NUM_SOURCES = 4;
	localparam logic [31:0] RANDOM_SEED = 32'h32e3629b;

	// Transaction kinds in the first column of plic_tests.dat.
	localparam logic [3:0] KIND_IDLE = 4'd0;
	localparam logic [3:0] KIND_ENABLE_WRITE = 4'd1;
	localparam logic [3:0] KIND_CLAIM_READ = 4'd2;
	localparam logic [3:0] KIND_COMPLETE_WRITE = 4'd3;
	localparam logic [3:0] KIND_OTHER_READ = 4'd4;

	// One line of the test file.
	typedef struct packed {
		logic [3:0] kind;
		logic [6:0] sources;
		logic irq_enable;
		plic_pkg::data_t wdata;
		plic_pkg::data_t rdata;
		logic [7:0] pulses;
	} test_line_t;

	test_line_t lines[$];

	logic clock;
	logic reset;
	logic [NUM_SOURCES-1:0] sources;
	logic interrupt_enable;
	logic request;
	logic rw;
	plic_pkg::address_t address;
	plic_pkg::data_t wdata;
	plic_pkg::data_t rdata;
	logic ready;
	logic interrupt;

	// Expected values handed to the checker.
	logic line_done;
	int line_number;
	plic_pkg::data_t expected_rdata;
	int expected_readies;
	int expected_pulses;
	int error_count;

	int cycles;
	int cycle_limit;

	always #50 clock = ~clock;

	plic_top #(
		.NUM_SOURCES(NUM_SOURCES)
	) plic_top_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_sources(sources),
		.i_interrupt_enable(interrupt_enable),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_interrupt(interrupt)
	);

	plic_checker plic_checker_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_ready(ready),
		.i_rdata(rdata),
		.i_interrupt(interrupt),
		.i_line_done(line_done),
		.i_line_number(line_number),
		.i_expected_rdata(expected_rdata),
		.i_expected_readies(expected_readies),
		.i_expected_pulses(expected_pulses),
		.o_error_count(error_count)
	);

	// ############################################################
	// Test file and request driving
	// ############################################################

	task automatic load_tests(output logic loaded);
		int fd;
		int fields;
		int kind;
		int pulses;
		logic [31:0] line_sources;
		logic [31:0] line_enable;
		logic [31:0] line_wdata;
		logic [31:0] line_rdata;
		string text;
		test_line_t entry;
		fd = $fopen("plic_tests.dat", "r");
		loaded = 1'b0;
		if (fd != 0) begin
			while (!$feof(fd)) begin
				text = "";
				fields = $fgets(text, fd);
				if (text.len() > 0 && text.getc(0) != "#") begin
					fields = $sscanf(text, "%d %h %h %h %h %d", kind, line_sources,
						line_enable, line_wdata, line_rdata, pulses);
					if (fields == 6) begin
						entry.kind = kind[3:0];
						entry.sources = line_sources[6:0];
						entry.irq_enable = line_enable[0];
						entry.wdata = line_wdata;
						entry.rdata = line_rdata;
						entry.pulses = pulses[7:0];
						lines.push_back(entry);
					end
				end
			end
			$fclose(fd);
			loaded = (lines.size() > 0);
		end
	endtask

	function automatic int ready_count_for(input logic [3:0] kind);
		if (kind == KIND_IDLE) begin
			return 0;
		end
		// Two reads go out back to back.
		if (kind == KIND_OTHER_READ) begin
			return 2;
		end
		return 1;
	endfunction

	task automatic start_request(input logic [3:0] kind, input plic_pkg::data_t data);
		request = (kind != KIND_IDLE);
		rw = (kind == KIND_ENABLE_WRITE) || (kind == KIND_COMPLETE_WRITE);
		wdata = data;
		case (kind)
			KIND_ENABLE_WRITE: address = plic_pkg::ENABLE_ADDRESS;
			// The data column holds the unknown address.
			KIND_OTHER_READ: address = data[23:0];
			default: address = plic_pkg::CLAIM_ADDRESS;
		endcase
	endtask

	task automatic run_line(input int index);
		test_line_t entry;
		entry = lines[index];
		@(negedge clock);
		line_number = index + 1;
		sources = entry.sources[NUM_SOURCES-1:0];
		interrupt_enable = entry.irq_enable;
		expected_rdata = entry.rdata;
		expected_readies = ready_count_for(entry.kind);
		expected_pulses = int'(entry.pulses);
		start_request(entry.kind, entry.wdata);
		@(negedge clock);
		if (entry.kind == KIND_OTHER_READ) begin
			address = plic_pkg::ENABLE_ADDRESS;
			@(negedge clock);
		end
		request = 1'b0;
		while (entry.kind != KIND_IDLE && !ready) begin
			@(negedge clock);
		end
		// A new source level reaches o_interrupt within three more edges.
		repeat (3) @(negedge clock);
		line_done = 1'b1;
		@(negedge clock);
		line_done = 1'b0;
	endtask

	// ############################################################
	// Run
	// ############################################################

	always @(posedge clock) begin
		if (cycle_limit > 0) begin
			cycles = cycles + 1;
			if (cycles >= cycle_limit) begin
				$display("Timeout after %0d cycles, the test lines did not finish", cycles);
				$display("Something failed");
				$finish;
			end
		end
	end

	initial begin
		logic loaded;
		int gap;
		clock = 1'b0;
		reset = 1'b1;
		sources = '0;
		interrupt_enable = 1'b0;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		line_done = 1'b0;
		line_number = 0;
		expected_rdata = '0;
		expected_readies = 0;
		expected_pulses = 0;
		cycles = 0;
		cycle_limit = 0;
		void'($urandom(RANDOM_SEED));
		load_tests(loaded);
		if (!loaded) begin
			$display("No test lines could be read from plic_tests.dat");
			$display("Something failed");
			$finish;
		end
		else begin
			cycle_limit = lines.size() * (8 + 3) + 20;
			repeat (3) @(posedge clock);
			@(negedge clock);
			reset = 1'b0;
			for (int n = 0; n < lines.size(); n++) begin
				run_line(n);
				gap = int'($urandom % 4);
				repeat (gap) @(negedge clock);
			end
			@(negedge clock);
			$display("Ran %0d test lines, %0d errors", lines.size(), error_count);
			if (error_count == 0) begin
				$display("Everything OK");
			end
			else begin
				$display("Something failed");
			end
			$finish;
		end
	end

endmodule

// File: plic_checker.sv
`timescale 1ns/1ps

module plic_checker (
	input logic i_clock,
	input logic i_reset,

	// DUT outputs.
	input logic i_ready,
	input plic_pkg::data_t i_rdata,
	input logic i_interrupt,

	// Expected values from the driver, valid for the current line.
	input logic i_line_done,
	input int i_line_number,
	input plic_pkg::data_t i_expected_rdata,
	input int i_expected_readies,
	input int i_expected_pulses,

	output int o_error_count
);

	int ready_count;
	int pulse_count;
	int error_count;

	initial begin
		ready_count = 0;
		pulse_count = 0;
		error_count = 0;
	end

	assign o_error_count = error_count;

	// Outputs are flops, so the value seen here is the one held before the edge.
	always @(posedge i_clock) begin
		int readies_now;
		int pulses_now;
		if (i_reset) begin
			ready_count = 0;
			pulse_count = 0;
		end
		else begin
			readies_now = ready_count + (i_ready ? 1 : 0);
			pulses_now = pulse_count + (i_interrupt ? 1 : 0);

			// Read data only carries a value in the ready cycle.
			if (i_ready && i_rdata != i_expected_rdata) begin
				$display("CHECK FAILED o_rdata line %0d: expected %h, got %h",
					i_line_number, i_expected_rdata, i_rdata);
				error_count++;
			end
			else if (!i_ready && i_rdata != '0) begin
				$display("CHECK FAILED o_rdata line %0d: expected %h, got %h",
					i_line_number, 32'h0, i_rdata);
				error_count++;
			end

			if (i_line_done) begin
				if (readies_now != i_expected_readies) begin
					$display("Line %0d: o_ready pulsed %0d times where %0d were expected",
						i_line_number, readies_now, i_expected_readies);
					error_count++;
				end
				if (pulses_now != i_expected_pulses) begin
					$display("Line %0d: o_interrupt pulsed %0d times where %0d were expected",
						i_line_number, pulses_now, i_expected_pulses);
					error_count++;
				end
				readies_now = 0;
				pulses_now = 0;
			end

			ready_count = readies_now;
			pulse_count = pulses_now;
		end
	end

endmodule

// File: plic_top.sv
`timescale 1ns/1ps

module plic_top #(
	parameter int NUM_SOURCES = 4
) (
	input logic i_clock,
	input logic i_reset,

	// Interrupt sources and global enable.
	input logic [NUM_SOURCES-1:0] i_sources,
	input logic i_interrupt_enable,

	// CPU strobe interface.
	input logic i_request,
	input logic i_rw,
	input plic_pkg::address_t i_address,
	input plic_pkg::data_t i_wdata,
	output plic_pkg::data_t o_rdata,
	output logic o_ready,

	// Notification toward the CPU.
	output logic o_interrupt
);

	// ############################################################
	// Internal wiring
	// ############################################################

	logic [NUM_SOURCES-1:0] source_level;
	plic_pkg::plic_cmd_t cmd;
	plic_pkg::source_id_t claim_id;
	logic any_pending;

	// Sync stage.
	plic_gateway #(
		.NUM_SOURCES(NUM_SOURCES)
	) plic_gateway_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_sources(i_sources),
		.o_source_level(source_level)
	);

	// Enable, pending and claim.
	plic_core #(
		.NUM_SOURCES(NUM_SOURCES)
	) plic_core_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_source_level(source_level),
		.i_interrupt_enable(i_interrupt_enable),
		.i_cmd(cmd),
		.o_claim_id(claim_id),
		.o_any_pending(any_pending)
	);

	// CPU side, beside the core.
	plic_bus_port plic_bus_port_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_claim_id(claim_id),
		.o_cmd(cmd),
		.o_rdata(o_rdata),
		.o_ready(o_ready)
	);

	// Pulse generation.
	plic_notify plic_notify_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_interrupt_enable(i_interrupt_enable),
		.i_any_pending(any_pending),
		.i_cmd(cmd),
		.o_interrupt(o_interrupt)
	);

endmodule

// File: plic_notify.sv
`timescale 1ns/1ps

module plic_notify (
	input logic i_clock,
	input logic i_reset,

	input logic i_interrupt_enable,
	input logic i_any_pending,

	// Only the complete bit is used here.
	input plic_pkg::plic_cmd_t i_cmd,

	// One-cycle pulse toward the CPU.
	output logic o_interrupt
);

	// Set once a pulse went out, until the CPU completes.
	logic issued;

	// Conditions for a new pulse on the next edge.
	logic fire;

	assign fire = i_interrupt_enable && i_any_pending && !issued;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_interrupt <= 1'b0;
			issued <= 1'b0;
		end
		else begin
			o_interrupt <= fire;

			// fire already implies issued is clear.
			if (fire) begin
				issued <= 1'b1;
			end
			else if (i_cmd.complete) begin
				issued <= 1'b0;
			end
		end
	end

	// Notification is a pulse, never a level.
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_interrupt |=> !o_interrupt)
	else
		$error("plic_notify: o_interrupt high for two cycles");

endmodule

// File: plic_bus_port.sv
`timescale 1ns/1ps

module plic_bus_port (
	input logic i_clock,
	input logic i_reset,

	// CPU strobe interface.
	input logic i_request,
	input logic i_rw,
	input plic_pkg::address_t i_address,
	input plic_pkg::data_t i_wdata,

	// Current lowest pending ID from the core.
	input plic_pkg::source_id_t i_claim_id,

	output plic_pkg::plic_cmd_t o_cmd,
	output plic_pkg::data_t o_rdata,
	output logic o_ready
);

	plic_pkg::plic_cmd_t cmd;

	// ############################################################
	// Request decode
	// ############################################################

	// rw high is a write.
	always_comb begin
		cmd.claim = i_request && !i_rw && (i_address == plic_pkg::CLAIM_ADDRESS);
		cmd.complete = i_request && i_rw && (i_address == plic_pkg::CLAIM_ADDRESS);
		cmd.enable_write = i_request && i_rw && (i_address == plic_pkg::ENABLE_ADDRESS);
		cmd.enable_value = i_wdata;
	end

	assign o_cmd = cmd;

	// ############################################################
	// Response
	// ############################################################

	// Any other read returns zero.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_rdata <= '0;
		end
		else begin
			o_ready <= i_request;
			o_rdata <= cmd.claim ? plic_pkg::data_t'(i_claim_id) : '0;
		end
	end

	// Every request gets exactly one ready, one cycle later.
	assert property (@(posedge i_clock) disable iff (i_reset)
		1'b1 |=> (o_ready == $past(i_request)))
	else
		$error("plic_bus_port: o_ready does not follow i_request");

endmodule

// File: plic_core.sv
`timescale 1ns/1ps

module plic_core #(
	parameter int NUM_SOURCES = 4
) (
	input logic i_clock,
	input logic i_reset,

	// Synchronized source levels, bit n-1 is source n.
	input logic [NUM_SOURCES-1:0] i_source_level,
	input logic i_interrupt_enable,

	// Decoded command from the bus port.
	input plic_pkg::plic_cmd_t i_cmd,

	// Lowest pending ID, 0 when idle.
	output plic_pkg::source_id_t o_claim_id,
	output logic o_any_pending
);

	// ############################################################
	// State
	// ############################################################

	logic [NUM_SOURCES-1:0] enable;
	logic [NUM_SOURCES-1:0] pending;

	// Sources that become pending on the next edge.
	logic [NUM_SOURCES-1:0] set_mask;

	// One-hot of the lowest pending bit.
	logic [NUM_SOURCES-1:0] lowest_mask;

	// Bit removed by a claim on the next edge.
	logic [NUM_SOURCES-1:0] clear_mask;

	plic_pkg::source_id_t claim_id;

	// ############################################################
	// Claim selection
	// ############################################################

	// Walk down so the lowest set bit is the last one written.
	always_comb begin
		claim_id = '0;
		lowest_mask = '0;
		for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
			if (pending[i]) begin
				claim_id = plic_pkg::source_id_t'(i + 1);
				lowest_mask = '0;
				lowest_mask[i] = 1'b1;
			end
		end
	end

	// Level sources gated by enable and the global enable.
	assign set_mask = i_interrupt_enable ? (i_source_level & enable) : '0;

	assign clear_mask = i_cmd.claim ? lowest_mask : '0;

	// ############################################################
	// Registers
	// ############################################################

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			enable <= '0;
			pending <= '0;
		end
		else begin
			// Bit 0 of the write data is reserved.
			if (i_cmd.enable_write) begin
				enable <= i_cmd.enable_value[NUM_SOURCES:1];
			end

			// Claim clear wins over a set on the same bit.
			pending <= (pending | set_mask) & ~clear_mask;
		end
	end

	assign o_claim_id = claim_id;
	assign o_any_pending = |pending;

	// A claim ID beyond the source count would name a missing source.
	assert property (@(posedge i_clock) disable iff (i_reset)
		32'(o_claim_id) <= NUM_SOURCES)
	else
		$error("plic_core: claim ID %0d above NUM_SOURCES", o_claim_id);

endmodule

// File: plic_gateway.sv
`timescale 1ns/1ps

module plic_gateway #(
	parameter int NUM_SOURCES = 4
) (
	input logic i_clock,
	input logic i_reset,

	// Raw asynchronous source levels.
	input logic [NUM_SOURCES-1:0] i_sources,

	// Levels in the clock domain, two flops later.
	output logic [NUM_SOURCES-1:0] o_source_level
);

	// First stage, may go metastable.
	logic [NUM_SOURCES-1:0] sync_meta;

	// Second stage settles before it is used.
	logic [NUM_SOURCES-1:0] sync_level;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sync_meta <= '0;
			sync_level <= '0;
		end
		else begin
			sync_meta <= i_sources;
			sync_level <= sync_meta;
		end
	end

	assign o_source_level = sync_level;

	// Source count must fit the 3-bit ID space, with ID 0 left free.
	assert property (@(posedge i_clock)
		(NUM_SOURCES >= 1) && (NUM_SOURCES <= plic_pkg::MAX_SOURCES))
	else
		$error("plic_gateway: NUM_SOURCES %0d out of range", NUM_SOURCES);

endmodule

// File: plic_pkg.sv
package plic_pkg;

	// ############################################################
	// Bus widths and source IDs
	// ############################################################

	localparam int ADDRESS_WIDTH = 24;
	localparam int DATA_WIDTH = 32;
	localparam int SOURCE_ID_WIDTH = 3;

	// Upper bound on the source count.
	// ID 0 is reserved for "nothing pending".
	localparam int MAX_SOURCES = (1 << SOURCE_ID_WIDTH) - 1;

	// CPU byte address.
	typedef logic [ADDRESS_WIDTH-1:0] address_t;

	// CPU data word.
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Interrupt source ID, 0 means none.
	typedef logic [SOURCE_ID_WIDTH-1:0] source_id_t;

	// ############################################################
	// Register map
	// ############################################################

	// Enable bits for context 0.
	localparam address_t ENABLE_ADDRESS = 24'h002000;

	// Claim on read, complete on write.
	localparam address_t CLAIM_ADDRESS = 24'h200004;

	// Decoded CPU request, valid in the request cycle only.
	typedef struct packed {
		logic claim;
		logic complete;
		logic enable_write;
		data_t enable_value;
	} plic_cmd_t;

endpackage
